// ==== hw/divsqrt_pkg.sv ====
/*
 * Shared definitions of the divide and square-root accelerator: field widths,
 * instruction encodings, the decoded operation enum and the tag and status structs
 */
package divsqrt_pkg;

  // --------------------------------------------------------------------------
  // Field widths
  // --------------------------------------------------------------------------
  localparam int unsigned HartIdWidth = 6;
  localparam int unsigned RdWidth     = 5;
  localparam int unsigned OpcodeWidth = 7;

  // --------------------------------------------------------------------------
  // Instruction encoding
  // --------------------------------------------------------------------------
  // Major opcode in bits 6:0, custom-0 space
  localparam logic [OpcodeWidth-1:0] OpcodeDivsqrt = 7'b0001011;

  // Operation select in bits 14:12
  localparam int unsigned Funct3Lsb  = 12;
  localparam logic [2:0]  Funct3Divu = 3'b101;
  localparam logic [2:0]  Funct3Remu = 3'b111;
  localparam logic [2:0]  Funct3Sqrt = 3'b011;

  // Destination register in bits 11:7
  localparam int unsigned RdLsb = 7;

  // --------------------------------------------------------------------------
  // Types
  // --------------------------------------------------------------------------
  // Decoded operation handed to a lane
  typedef enum logic [1:0] {
    OP_DIVU,
    OP_REMU,
    OP_SQRT,
    OP_ILLEGAL
  } divsqrt_op_e;

  // Carried through a lane unchanged, identifies the response
  typedef struct packed {
    logic [RdWidth-1:0]     rd;
    logic [HartIdWidth-1:0] hart_id;
  } divsqrt_tag_t;

  // Exception flags
  typedef struct packed {
    logic dz;  // divide by zero
    logic nv;  // invalid operation
  } divsqrt_status_t;

endpackage

// ==== hw/divsqrt_if.sv ====
/*
 * Lane interface: issue half from the dispatcher, result half to the collector
 */
interface divsqrt_if #(
  parameter int unsigned Width = 32
) ();

  // Issue half
  logic                          in_valid;
  logic                          in_ready;
  divsqrt_pkg::divsqrt_op_e      op;
  logic [Width-1:0]              opa;
  logic [Width-1:0]              opb;
  divsqrt_pkg::divsqrt_tag_t     in_tag;

  // Result half
  logic                          out_valid;
  logic                          out_ready;
  logic [Width-1:0]              result;
  divsqrt_pkg::divsqrt_status_t  status;
  logic                          error;
  divsqrt_pkg::divsqrt_tag_t     out_tag;

  modport dispatch (
    output in_valid, op, opa, opb, in_tag,
    input  in_ready
  );

  modport lane (
    input  in_valid, op, opa, opb, in_tag, out_ready,
    output in_ready, out_valid, result, status, error, out_tag
  );

  modport collect (
    input  out_valid, result, status, error, out_tag,
    output out_ready
  );

endinterface

// ==== hw/divsqrt_dispatch.sv ====
/*
 * Request decoder and lane dispatcher with the registered issue event
 */
module divsqrt_dispatch #(
  parameter int unsigned NumLanes = 2,
  parameter int unsigned Width    = 32
) (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  // Request port
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  input  logic [31:0]                         req_instr_i,
  input  logic [Width-1:0]                    req_opa_i,
  input  logic [Width-1:0]                    req_opb_i,
  input  logic [divsqrt_pkg::HartIdWidth-1:0] req_hart_id_i,
  // Core event strobe
  output logic                                issue_evt_o,
  // Issue side of every lane
  divsqrt_if.dispatch                         lanes_o [NumLanes]
);

  divsqrt_pkg::divsqrt_op_e  op;
  divsqrt_pkg::divsqrt_tag_t tag;
  logic [2:0]                funct3;

  logic [NumLanes-1:0] lane_ready;
  logic [NumLanes-1:0] lane_sel;
  logic [NumLanes-1:0] lane_valid;
  logic                issue_evt_q;

  // --------------------------------------------------------------------------
  // Decode
  // --------------------------------------------------------------------------
  assign funct3 = req_instr_i[divsqrt_pkg::Funct3Lsb +: 3];

  always_comb begin
    op = divsqrt_pkg::OP_ILLEGAL;
    if (req_instr_i[divsqrt_pkg::OpcodeWidth-1:0] == divsqrt_pkg::OpcodeDivsqrt) begin
      case (funct3)
        divsqrt_pkg::Funct3Divu: op = divsqrt_pkg::OP_DIVU;
        divsqrt_pkg::Funct3Remu: op = divsqrt_pkg::OP_REMU;
        divsqrt_pkg::Funct3Sqrt: op = divsqrt_pkg::OP_SQRT;
        default:                 op = divsqrt_pkg::OP_ILLEGAL;
      endcase
    end
  end

  assign tag.rd      = req_instr_i[divsqrt_pkg::RdLsb +: divsqrt_pkg::RdWidth];
  assign tag.hart_id = req_hart_id_i;

  // --------------------------------------------------------------------------
  // Lane selection
  // --------------------------------------------------------------------------
  // Lowest-index idle lane wins
  always_comb begin
    logic found;
    found    = 1'b0;
    lane_sel = '0;
    for (int unsigned i = 0; i < NumLanes; i++) begin
      if (!found && lane_ready[i]) begin
        lane_sel[i] = 1'b1;
        found       = 1'b1;
      end
    end
  end

  assign req_ready_o = |lane_ready;
  assign lane_valid  = lane_sel & {NumLanes{req_valid_i}};

  // Operands and tag are broadcast, only in_valid selects the lane
  for (genvar i = 0; i < NumLanes; i++) begin : gen_issue
    assign lane_ready[i]      = lanes_o[i].in_ready;
    assign lanes_o[i].in_valid = lane_valid[i];
    assign lanes_o[i].op       = op;
    assign lanes_o[i].opa      = req_opa_i;
    assign lanes_o[i].opb      = req_opb_i;
    assign lanes_o[i].in_tag   = tag;
  end

  // --------------------------------------------------------------------------
  // Issue event
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      issue_evt_q <= 1'b0;
    end else begin
      issue_evt_q <= req_valid_i & req_ready_o;
    end
  end

  assign issue_evt_o = issue_evt_q;

  // Never hand one request to two lanes
  a_single_issue : assert property (
    @(posedge clk_i) disable iff (!arst_n_i) $onehot0(lane_valid)
  );

endmodule

// ==== hw/divsqrt_lane.sv ====
/*
 * Iterative radix-2 lane: restoring divider and digit-by-digit square root,
 * result held until drained by the collector
 */
module divsqrt_lane #(
  parameter int unsigned Width = 32
) (
  input  logic    clk_i,
  input  logic    arst_n_i,
  divsqrt_if.lane lane_io
);

  // Two spare bits so the square-root remainder never overflows
  localparam int unsigned AccW = Width + 2;
  localparam int unsigned CntW = $clog2(Width + 1);

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DONE
  } state_e;

  state_e                    state_q;
  logic [CntW-1:0]           cnt_q;
  logic [CntW-1:0]           cnt_load;
  divsqrt_pkg::divsqrt_op_e  op_q;
  divsqrt_pkg::divsqrt_tag_t tag_q;
  logic                      dz_q;

  // Partial remainder, quotient or root, divisor or radicand
  logic [AccW-1:0]  acc_q;
  logic [Width-1:0] quo_q;
  logic [Width-1:0] opr_q;

  logic            accept;
  logic            div_op;
  logic            zero_div;
  logic            is_sqrt;
  logic            step_en;
  logic            busy_step;
  logic [AccW-1:0] shifted;
  logic [AccW-1:0] subtrahend;
  logic [AccW:0]   diff;
  logic            ge;

  assign accept   = lane_io.in_valid & lane_io.in_ready;
  assign div_op   = (lane_io.op == divsqrt_pkg::OP_DIVU) | (lane_io.op == divsqrt_pkg::OP_REMU);
  assign zero_div = div_op & (lane_io.opb == '0);

  // Iteration count for the accepted operation
  always_comb begin
    case (lane_io.op)
      divsqrt_pkg::OP_DIVU,
      divsqrt_pkg::OP_REMU: cnt_load = zero_div ? CntW'(1) : CntW'(Width);
      divsqrt_pkg::OP_SQRT: cnt_load = CntW'(Width / 2);
      default:              cnt_load = CntW'(1);
    endcase
  end

  // --------------------------------------------------------------------------
  // Datapath step
  // --------------------------------------------------------------------------
  assign is_sqrt = (op_q == divsqrt_pkg::OP_SQRT);
  assign step_en = is_sqrt |
                   (((op_q == divsqrt_pkg::OP_DIVU) | (op_q == divsqrt_pkg::OP_REMU)) & ~dz_q);
  assign busy_step = (state_q == BUSY) & (cnt_q != '0) & step_en;

  // One shared subtractor, trial value 4r+1 for the root
  always_comb begin
    if (is_sqrt) begin
      shifted    = {acc_q[AccW-3:0], opr_q[Width-1 -: 2]};
      subtrahend = {quo_q, 2'b01};
    end else begin
      shifted    = {acc_q[AccW-2:0], quo_q[Width-1]};
      subtrahend = {2'b00, opr_q};
    end
    diff = {1'b0, shifted} - {1'b0, subtrahend};
    ge   = ~diff[AccW];
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q  <= lane_io.op;
      tag_q <= lane_io.in_tag;
      dz_q  <= zero_div;
      if (lane_io.op == divsqrt_pkg::OP_SQRT) begin
        acc_q <= '0;
        quo_q <= '0;
        opr_q <= lane_io.opa;
      end else if (zero_div) begin
        // Final values straight away
        acc_q <= {2'b00, lane_io.opa};
        quo_q <= '1;
        opr_q <= lane_io.opb;
      end else begin
        acc_q <= '0;
        quo_q <= lane_io.opa;
        opr_q <= lane_io.opb;
      end
    end else if (busy_step) begin
      acc_q <= ge ? diff[AccW-1:0] : shifted;
      quo_q <= {quo_q[Width-2:0], ge};
      if (is_sqrt) begin
        opr_q <= opr_q << 2;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Control
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (accept) begin
            state_q <= BUSY;
            cnt_q   <= cnt_load;
          end
        end
        BUSY: begin
          if (cnt_q == '0) begin
            state_q <= DONE;
          end else begin
            cnt_q <= cnt_q - CntW'(1);
          end
        end
        DONE: begin
          if (lane_io.out_ready) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  assign lane_io.in_ready  = (state_q == IDLE);
  assign lane_io.out_valid = (state_q == DONE);
  assign lane_io.out_tag   = tag_q;

  // Result select by operation
  always_comb begin
    lane_io.result = '0;
    lane_io.status = '0;
    lane_io.error  = 1'b0;
    case (op_q)
      divsqrt_pkg::OP_DIVU: begin
        lane_io.result    = quo_q;
        lane_io.status.dz = dz_q;
      end
      divsqrt_pkg::OP_REMU: begin
        lane_io.result    = acc_q[Width-1:0];
        lane_io.status.dz = dz_q;
      end
      divsqrt_pkg::OP_SQRT: lane_io.result = quo_q;
      default: begin
        lane_io.error     = 1'b1;
        lane_io.status.nv = 1'b1;
      end
    endcase
  end

  // Dispatcher only offers work to an idle lane
  a_issue_when_idle : assert property (
    @(posedge clk_i) disable iff (!arst_n_i) lane_io.in_valid |-> (state_q == IDLE)
  );

endmodule

// ==== hw/divsqrt_collect.sv ====
/*
 * Round-robin collector draining finished lanes onto the response port
 */
module divsqrt_collect #(
  parameter int unsigned NumLanes = 2,
  parameter int unsigned Width    = 32
) (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  logic                                resp_ready_i,
  divsqrt_if.collect                          lanes_i [NumLanes],
  output logic                                resp_valid_o,
  output logic [Width-1:0]                    resp_data_o,
  output logic [divsqrt_pkg::RdWidth-1:0]     resp_rd_o,
  output logic [divsqrt_pkg::HartIdWidth-1:0] resp_hart_id_o,
  output divsqrt_pkg::divsqrt_status_t        resp_status_o,
  output logic                                resp_error_o
);

  localparam int unsigned IdxW = (NumLanes > 1) ? $clog2(NumLanes) : 1;

  logic                         valid_vec [NumLanes];
  logic [Width-1:0]             data_arr  [NumLanes];
  divsqrt_pkg::divsqrt_status_t status_arr[NumLanes];
  logic                         error_arr [NumLanes];
  divsqrt_pkg::divsqrt_tag_t    tag_arr   [NumLanes];

  logic [IdxW-1:0] last_q;
  logic [IdxW-1:0] gnt_q;
  logic            lock_q;
  logic [IdxW-1:0] rr_idx;
  logic [IdxW-1:0] gnt_idx;

  for (genvar i = 0; i < NumLanes; i++) begin : gen_gather
    assign valid_vec[i]  = lanes_i[i].out_valid;
    assign data_arr[i]   = lanes_i[i].result;
    assign status_arr[i] = lanes_i[i].status;
    assign error_arr[i]  = lanes_i[i].error;
    assign tag_arr[i]    = lanes_i[i].out_tag;
    assign lanes_i[i].out_ready = resp_ready_i & valid_vec[i] & (gnt_idx == IdxW'(i));
  end

  // --------------------------------------------------------------------------
  // Arbitration
  // --------------------------------------------------------------------------
  // First valid lane after the one served last
  always_comb begin
    int unsigned cand;
    logic        found;
    rr_idx = last_q;
    found  = 1'b0;
    for (int unsigned off = 1; off <= NumLanes; off++) begin
      cand = int'(last_q) + off;
      if (cand >= NumLanes) begin
        cand = cand - NumLanes;
      end
      if (!found && valid_vec[cand]) begin
        rr_idx = IdxW'(cand);
        found  = 1'b1;
      end
    end
  end

  // Stalled response keeps its lane
  assign gnt_idx = lock_q ? gnt_q : rr_idx;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_q <= IdxW'(NumLanes - 1);
      gnt_q  <= '0;
      lock_q <= 1'b0;
    end else begin
      lock_q <= resp_valid_o & ~resp_ready_i;
      gnt_q  <= gnt_idx;
      if (resp_valid_o && resp_ready_i) begin
        last_q <= gnt_idx;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Response mux
  // --------------------------------------------------------------------------
  assign resp_valid_o   = valid_vec[gnt_idx];
  assign resp_data_o    = data_arr[gnt_idx];
  assign resp_status_o  = status_arr[gnt_idx];
  assign resp_error_o   = error_arr[gnt_idx];
  assign resp_rd_o      = tag_arr[gnt_idx].rd;
  assign resp_hart_id_o = tag_arr[gnt_idx].hart_id;

  // Lane must hold its result while the response is stalled
  a_resp_stable : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_data_o) &&
      $stable(resp_rd_o) && $stable(resp_hart_id_o) && $stable(resp_status_o) &&
      $stable(resp_error_o)
  );

endmodule

// ==== hw/divsqrt_subsystem.sv ====
/*
 * Top level: dispatcher, lane interface array, generated lanes and collector
 */
module divsqrt_subsystem #(
  parameter int unsigned NumLanes = 2,
  parameter int unsigned Width    = 32
) (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  // Request port
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  input  logic [31:0]                         req_instr_i,
  input  logic [Width-1:0]                    req_opa_i,
  input  logic [Width-1:0]                    req_opb_i,
  input  logic [divsqrt_pkg::HartIdWidth-1:0] req_hart_id_i,
  // Response port
  output logic                                resp_valid_o,
  input  logic                                resp_ready_i,
  output logic [Width-1:0]                    resp_data_o,
  output logic [divsqrt_pkg::RdWidth-1:0]     resp_rd_o,
  output logic [divsqrt_pkg::HartIdWidth-1:0] resp_hart_id_o,
  output divsqrt_pkg::divsqrt_status_t        resp_status_o,
  output logic                                resp_error_o,
  // Core event strobe
  output logic                                issue_evt_o
);

  // One interface per lane
  divsqrt_if #(.Width(Width)) lane_if [NumLanes] ();

  // --------------------------------------------------------------------------
  // Dispatcher
  // --------------------------------------------------------------------------
  divsqrt_dispatch #(
    .NumLanes ( NumLanes ),
    .Width    ( Width    )
  ) i_dispatch (
    .clk_i,
    .arst_n_i,
    .req_valid_i,
    .req_ready_o,
    .req_instr_i,
    .req_opa_i,
    .req_opb_i,
    .req_hart_id_i,
    .issue_evt_o,
    .lanes_o       ( lane_if )
  );

  // Identical iterative lanes
  for (genvar i = 0; i < NumLanes; i++) begin : gen_lane
    divsqrt_lane #(
      .Width ( Width )
    ) i_lane (
      .clk_i,
      .arst_n_i,
      .lane_io  ( lane_if[i] )
    );
  end

  // --------------------------------------------------------------------------
  // Collector
  // --------------------------------------------------------------------------
  divsqrt_collect #(
    .NumLanes ( NumLanes ),
    .Width    ( Width    )
  ) i_collect (
    .clk_i,
    .arst_n_i,
    .resp_ready_i,
    .lanes_i        ( lane_if ),
    .resp_valid_o,
    .resp_data_o,
    .resp_rd_o,
    .resp_hart_id_o,
    .resp_status_o,
    .resp_error_o
  );

endmodule

// ==== sim/tb_divsqrt.sv ====
/*
 * Testbench of the divide and square-root subsystem: clock, reset, DUT,
 * directed tests, compare tasks and the closing summary
 */
module tb_divsqrt;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NumLanes   = 2;
  localparam int unsigned Width      = 32;
  localparam int unsigned WaitLimit  = 4 * Width + 40;
  localparam int unsigned HoldCycles = 3 * Width;

  logic                         clk;
  logic                         arst_n;
  logic                         req_valid;
  logic                         req_ready;
  logic [31:0]                  req_instr;
  logic [Width-1:0]             req_opa;
  logic [Width-1:0]             req_opb;
  logic [5:0]                   req_hart_id;
  logic                         resp_valid;
  logic                         resp_ready;
  logic [Width-1:0]             resp_data;
  logic [4:0]                   resp_rd;
  logic [5:0]                   resp_hart_id;
  divsqrt_pkg::divsqrt_status_t resp_status;
  logic                         resp_error;
  logic                         issue_evt;

  int unsigned errors;
  int unsigned tests_run;
  int unsigned tests_failed;
  int unsigned evt_count;

  divsqrt_subsystem i_dut (
    .clk_i          ( clk          ),
    .arst_n_i       ( arst_n       ),
    .req_valid_i    ( req_valid    ),
    .req_ready_o    ( req_ready    ),
    .req_instr_i    ( req_instr    ),
    .req_opa_i      ( req_opa      ),
    .req_opb_i      ( req_opb      ),
    .req_hart_id_i  ( req_hart_id  ),
    .resp_valid_o   ( resp_valid   ),
    .resp_ready_i   ( resp_ready   ),
    .resp_data_o    ( resp_data    ),
    .resp_rd_o      ( resp_rd      ),
    .resp_hart_id_o ( resp_hart_id ),
    .resp_status_o  ( resp_status  ),
    .resp_error_o   ( resp_error   ),
    .issue_evt_o    ( issue_evt    )
  );

  always #50 clk = ~clk;

  // Issue pulses, sampled away from the driving edge
  always @(negedge clk) begin
    if (arst_n && issue_evt) begin
      evt_count++;
    end
  end

  // --------------------------------------------------------------------------
  // Reference helpers and compare tasks
  // --------------------------------------------------------------------------
  function automatic logic [31:0] make_instr(input logic [6:0] opcode,
                                             input logic [2:0] funct3,
                                             input logic [4:0] rd);
    logic [31:0] instr;
    instr = '0;
    instr[6:0] = opcode;
    instr[divsqrt_pkg::Funct3Lsb +: 3] = funct3;
    instr[divsqrt_pkg::RdLsb +: divsqrt_pkg::RdWidth] = rd;
    return instr;
  endfunction

  function automatic divsqrt_pkg::divsqrt_status_t make_status(input logic dz, input logic nv);
    divsqrt_pkg::divsqrt_status_t st;
    st.dz = dz;
    st.nv = nv;
    return st;
  endfunction

  // Largest r with r*r <= a
  function automatic logic [Width-1:0] floor_sqrt(input logic [Width-1:0] a);
    longint unsigned x;
    longint unsigned r;
    x = a;
    r = longint'($floor($sqrt(real'(x))));
    while (r * r > x) begin
      r--;
    end
    while ((r + 1) * (r + 1) <= x) begin
      r++;
    end
    return r[Width-1:0];
  endfunction

  task automatic check_data(input string name, input logic [Width-1:0] exp,
                            input logic [Width-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("** Error %s: data expected 0x%h, actual 0x%h", name, exp, act);
    end
  endtask

  task automatic check_status(input string name, input divsqrt_pkg::divsqrt_status_t exp,
                              input divsqrt_pkg::divsqrt_status_t act);
    if (act !== exp) begin
      errors++;
      $display("** Error %s: status expected dz=%b nv=%b, actual dz=%b nv=%b",
               name, exp.dz, exp.nv, act.dz, act.nv);
    end
  endtask

  task automatic check_bit(input string name, input string what, input logic exp,
                           input logic act);
    if (act !== exp) begin
      errors++;
      $display("** Error %s: %s expected %b, actual %b", name, what, exp, act);
    end
  endtask

  task automatic check_tag(input string name, input divsqrt_pkg::divsqrt_tag_t exp,
                           input divsqrt_pkg::divsqrt_tag_t act);
    if (act !== exp) begin
      errors++;
      $display("** Error %s: rd/hart expected %0d/%0d, actual %0d/%0d",
               name, exp.rd, exp.hart_id, act.rd, act.hart_id);
    end
  endtask

  task automatic finish_test(input string name, input int unsigned errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("PASS %s", name);
    end else begin
      tests_failed++;
      $display("FAIL %s with %0d errors", name, errors - errs_before);
    end
  endtask

  // --------------------------------------------------------------------------
  // Request and response tasks, entered 10 ns after a rising edge
  // --------------------------------------------------------------------------
  task automatic send_req(input string name, input logic [31:0] instr,
                          input logic [Width-1:0] opa, input logic [Width-1:0] opb,
                          input logic [5:0] hart, output logic ok);
    int unsigned waited;
    ok          = 1'b0;
    waited      = 0;
    req_valid   = 1'b1;
    req_instr   = instr;
    req_opa     = opa;
    req_opb     = opb;
    req_hart_id = hart;
    while (!ok && waited < WaitLimit) begin
      @(negedge clk);
      ok = req_ready;
      @(posedge clk);
      #10;
      waited++;
    end
    req_valid = 1'b0;
    if (!ok) begin
      errors++;
      $display("%s: timed out waiting for the request to be accepted", name);
    end
  endtask

  task automatic recv_resp(input string name, output logic [Width-1:0] data,
                           output divsqrt_pkg::divsqrt_tag_t tag,
                           output divsqrt_pkg::divsqrt_status_t status,
                           output logic error, output logic ok);
    int unsigned waited;
    ok         = 1'b0;
    waited     = 0;
    data       = '0;
    tag        = '0;
    status     = '0;
    error      = 1'b0;
    resp_ready = 1'b1;
    while (!ok && waited < WaitLimit) begin
      @(negedge clk);
      if (resp_valid) begin
        ok          = 1'b1;
        data        = resp_data;
        tag.rd      = resp_rd;
        tag.hart_id = resp_hart_id;
        status      = resp_status;
        error       = resp_error;
      end
      @(posedge clk);
      #10;
      waited++;
    end
    resp_ready = 1'b0;
    if (!ok) begin
      errors++;
      $display("%s: timed out waiting for a response", name);
    end
  endtask

  // One request, one response, all fields checked
  task automatic run_op(input string name, input logic [31:0] instr,
                        input logic [Width-1:0] opa, input logic [Width-1:0] opb,
                        input logic [5:0] hart, input logic [Width-1:0] exp_data,
                        input divsqrt_pkg::divsqrt_status_t exp_status,
                        input logic exp_error);
    logic                         ok;
    logic [Width-1:0]             data;
    divsqrt_pkg::divsqrt_tag_t    tag;
    divsqrt_pkg::divsqrt_tag_t    exp_tag;
    divsqrt_pkg::divsqrt_status_t status;
    logic                         error;
    exp_tag.rd      = instr[divsqrt_pkg::RdLsb +: divsqrt_pkg::RdWidth];
    exp_tag.hart_id = hart;
    send_req(name, instr, opa, opb, hart, ok);
    if (ok) begin
      recv_resp(name, data, tag, status, error, ok);
      if (ok) begin
        check_data(name, exp_data, data);
        check_status(name, exp_status, status);
        check_bit(name, "error", exp_error, error);
        check_tag(name, exp_tag, tag);
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic test_reset();
    int unsigned errs_before;
    errs_before = errors;
    @(negedge clk);
    check_bit("reset", "req_ready_o", 1'b1, req_ready);
    check_bit("reset", "resp_valid_o", 1'b0, resp_valid);
    check_bit("reset", "issue_evt_o", 1'b0, issue_evt);
    @(posedge clk);
    #10;
    finish_test("reset", errs_before);
  endtask

  task automatic test_divide();
    int unsigned      errs_before;
    logic [Width-1:0] a;
    logic [Width-1:0] b;
    logic [4:0]       rd;
    logic [5:0]       hart;
    errs_before = errors;
    for (int i = 0; i < 6; i++) begin
      a    = $urandom;
      b    = $urandom >> ($urandom % Width);
      rd   = $urandom;
      hart = $urandom;
      if (b == '0) begin
        b = 1;
      end
      run_op("divide", make_instr(divsqrt_pkg::OpcodeDivsqrt, divsqrt_pkg::Funct3Divu, rd),
             a, b, hart, a / b, make_status(1'b0, 1'b0), 1'b0);
      run_op("divide", make_instr(divsqrt_pkg::OpcodeDivsqrt, divsqrt_pkg::Funct3Remu, rd),
             a, b, hart, a % b, make_status(1'b0, 1'b0), 1'b0);
    end
    finish_test("divide", errs_before);
  endtask

  task automatic test_sqrt();
    int unsigned      errs_before;
    logic [Width-1:0] values [8];
    errs_before = errors;
    values[0] = '0;
    values[1] = 1;
    values[2] = '1;
    for (int i = 3; i < 8; i++) begin
      values[i] = $urandom >> ($urandom % Width);
    end
    foreach (values[i]) begin
      // opb carries junk, the lane must ignore it
      run_op("sqrt", make_instr(divsqrt_pkg::OpcodeDivsqrt, divsqrt_pkg::Funct3Sqrt, 5'(i)),
             values[i], $urandom, 6'(i), floor_sqrt(values[i]), make_status(1'b0, 1'b0), 1'b0);
    end
    finish_test("sqrt", errs_before);
  endtask

  task automatic test_div_zero();
    int unsigned      errs_before;
    logic [Width-1:0] a;
    errs_before = errors;
    a = $urandom;
    run_op("div_zero", make_instr(divsqrt_pkg::OpcodeDivsqrt, divsqrt_pkg::Funct3Divu, 5'd3),
           a, '0, 6'd12, '1, make_status(1'b1, 1'b0), 1'b0);
    run_op("div_zero", make_instr(divsqrt_pkg::OpcodeDivsqrt, divsqrt_pkg::Funct3Remu, 5'd4),
           a, '0, 6'd13, a, make_status(1'b1, 1'b0), 1'b0);
    finish_test("div_zero", errs_before);
  endtask

  task automatic test_illegal();
    int unsigned errs_before;
    errs_before = errors;
    // Wrong major opcode, then an unused funct3
    run_op("illegal", make_instr(7'b0110011, divsqrt_pkg::Funct3Divu, 5'd17),
           $urandom, $urandom, 6'd40, '0, make_status(1'b0, 1'b1), 1'b1);
    run_op("illegal", make_instr(divsqrt_pkg::OpcodeDivsqrt, 3'b000, 5'd18),
           $urandom, $urandom, 6'd41, '0, make_status(1'b0, 1'b1), 1'b1);
    finish_test("illegal", errs_before);
  endtask

  task automatic test_backpressure();
    int unsigned               errs_before;
    int unsigned               evt_start;
    int unsigned               accepted;
    int unsigned               got;
    int unsigned               waited;
    logic [31:0]               instr   [NumLanes+1];
    logic [Width-1:0]          opa     [NumLanes+1];
    logic [Width-1:0]          opb     [NumLanes+1];
    logic [Width-1:0]          exp_val [32];
    logic [5:0]                exp_hart[32];
    int                        rd_state[32];
    logic                      ok;
    logic                      pending;
    logic                      take_req;
    logic                      rose;
    divsqrt_pkg::divsqrt_tag_t exp_tag;
    divsqrt_pkg::divsqrt_tag_t act_tag;
    errs_before = errors;
    evt_start   = evt_count;
    accepted    = 0;
    rose        = 1'b0;
    resp_ready  = 1'b0;
    foreach (rd_state[r]) begin
      rd_state[r] = 0;
    end
    // Distinct rd per request, divides and remainders alternate
    for (int i = 0; i <= NumLanes; i++) begin
      opa[i] = $urandom;
      opb[i] = ($urandom >> ($urandom % Width)) | 1;
      instr[i] = make_instr(divsqrt_pkg::OpcodeDivsqrt,
                            (i % 2 == 0) ? divsqrt_pkg::Funct3Divu : divsqrt_pkg::Funct3Remu,
                            5'(20 + i));
      exp_val[20 + i]  = (i % 2 == 0) ? opa[i] / opb[i] : opa[i] % opb[i];
      exp_hart[20 + i] = 6'(30 + i);
      rd_state[20 + i] = 1;
    end
    for (int i = 0; i < NumLanes; i++) begin
      send_req("backpressure", instr[i], opa[i], opb[i], exp_hart[20 + i], ok);
      if (ok) begin
        accepted++;
      end
    end
    // Last request stays pending while every lane holds a result
    req_valid   = 1'b1;
    req_instr   = instr[NumLanes];
    req_opa     = opa[NumLanes];
    req_opb     = opb[NumLanes];
    req_hart_id = exp_hart[20 + NumLanes];
    pending     = 1'b1;
    for (waited = 0; waited < HoldCycles; waited++) begin
      @(negedge clk);
      if (req_ready && !rose) begin
        rose = 1'b1;
        errors++;
        $display("backpressure: req_ready_o went high while every lane was full");
      end
      @(posedge clk);
      #10;
    end
    // Release the response port and drain everything
    resp_ready = 1'b1;
    got        = 0;
    waited     = 0;
    while ((got < NumLanes + 1 || pending) && waited < WaitLimit) begin
      @(negedge clk);
      take_req = pending & req_ready;
      if (resp_valid) begin
        got++;
        if (rd_state[resp_rd] != 1) begin
          errors++;
          $display("backpressure: response for rd %0d was not expected or came twice",
                   resp_rd);
        end else begin
          rd_state[resp_rd] = 2;
          exp_tag.rd        = resp_rd;
          exp_tag.hart_id   = exp_hart[resp_rd];
          act_tag.rd        = resp_rd;
          act_tag.hart_id   = resp_hart_id;
          check_data("backpressure", exp_val[resp_rd], resp_data);
          check_tag("backpressure", exp_tag, act_tag);
          check_status("backpressure", make_status(1'b0, 1'b0), resp_status);
          check_bit("backpressure", "error", 1'b0, resp_error);
        end
      end
      @(posedge clk);
      #10;
      if (take_req) begin
        pending   = 1'b0;
        req_valid = 1'b0;
        accepted++;
      end
      waited++;
    end
    resp_ready = 1'b0;
    req_valid  = 1'b0;
    if (got < NumLanes + 1 || pending) begin
      errors++;
      $display("backpressure: timed out before every response arrived");
    end
    if (evt_count - evt_start != accepted) begin
      errors++;
      $display("** Error backpressure: issue events expected %0d, actual %0d",
               accepted, evt_count - evt_start);
    end
    finish_test("backpressure", errs_before);
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    void'($urandom(8980));
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    evt_count    = 0;
    clk          = 1'b0;
    arst_n       = 1'b0;
    req_valid    = 1'b0;
    req_instr    = '0;
    req_opa      = '0;
    req_opb      = '0;
    req_hart_id  = '0;
    resp_ready   = 1'b0;
    repeat (10) @(posedge clk);
    #10;
    arst_n = 1'b1;

    test_reset();
    test_divide();
    test_sqrt();
    test_div_zero();
    test_illegal();
    test_backpressure();

    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== files.f ====
hw/divsqrt_pkg.sv
hw/divsqrt_if.sv
hw/divsqrt_dispatch.sv
hw/divsqrt_lane.sv
hw/divsqrt_collect.sv
hw/divsqrt_subsystem.sv
sim/tb_divsqrt.sv
